//--- Bender.yml
package:
  name: micro_cpu

sources:
  - hdl/micro_pkg.sv
  - hdl/control_store.sv
  - hdl/micro_sequencer.sv
  - hdl/alu_datapath.sv
  - hdl/micro_cpu.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/micro_cpu_tb.sv

//--- files.f
hdl/micro_pkg.sv
hdl/control_store.sv
hdl/micro_sequencer.sv
hdl/alu_datapath.sv
hdl/micro_cpu.sv
tests/tb_clock_gen.sv
tests/micro_cpu_tb.sv

//--- hdl/alu_datapath.sv
/* ALU datapath with operand select, function unit and F result register.
   F and the carry flag load when the microword names F as destination. */

module alu_datapath import micro_pkg::*; #(
        parameter int DATA_WIDTH = 8
) (
        input  logic                  clk,
        input  logic                  rst_n,
        input  microword_t            microword,
        input  logic [DATA_WIDTH-1:0] input_a,
        input  logic [DATA_WIDTH-1:0] input_b,
        output logic [DATA_WIDTH-1:0] result,
        output logic                  carry
);

        logic [DATA_WIDTH-1:0] f_reg;     // F result register
        logic                  carry_reg;
        logic [DATA_WIDTH-1:0] a_op;
        logic [DATA_WIDTH-1:0] b_op;
        logic [DATA_WIDTH:0]   cin_ext;   // Carry in, widened
        logic [DATA_WIDTH:0]   sum_ext;   // Adder with carry out on top
        logic [DATA_WIDTH-1:0] alu_res;
        logic                  alu_cout;

        // Operand sources, input or F feedback
        assign a_op = microword.a_source ? input_a : f_reg;
        assign b_op = microword.b_source ? input_b : f_reg;

        assign cin_ext = {{DATA_WIDTH{1'b0}}, microword.cin};

        // Function unit
        always_comb begin
                sum_ext  = '0;
                alu_res  = '1;
                alu_cout = 1'b0;  // Logic ops clear carry
                case (microword.alu_func)
                ALU_ONE:  alu_res = '1;
                ALU_ZERO: alu_res = '0;
                ALU_A_PLUS_B: begin
                        sum_ext  = {1'b0, a_op} + {1'b0, b_op} + cin_ext;
                        alu_res  = sum_ext[DATA_WIDTH-1:0];
                        alu_cout = sum_ext[DATA_WIDTH];
                end
                ALU_A_MINUS_B: begin
                        // Carry set means no borrow
                        sum_ext  = {1'b0, a_op} + {1'b0, ~b_op} + cin_ext;
                        alu_res  = sum_ext[DATA_WIDTH-1:0];
                        alu_cout = sum_ext[DATA_WIDTH];
                end
                ALU_A_AND_B: alu_res = a_op & b_op;
                ALU_A_OR_B:  alu_res = a_op | b_op;
                ALU_A_XOR_B: alu_res = a_op ^ b_op;
                default:     alu_res = '1;  // Treated as ONE
                endcase
        end

        // F and carry
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        f_reg     <= '0;
                        carry_reg <= 1'b0;
                end else if (microword.alu_dest == DEST_F) begin
                        f_reg     <= alu_res;
                        carry_reg <= alu_cout;
                end
        end

        assign result = f_reg;
        assign carry  = carry_reg;

endmodule

//--- hdl/control_store.sv
/* Microcode ROM of 256 words by 24 bits.
   Reset flash, go_bar wait, opcode dispatch and five operation routines. */

module control_store import micro_pkg::*; (
        input  uaddr_t     microaddress,  // Address from sequencer
        output microword_t microword      // Word to sequencer and datapath
);

        // Background word, everything off and step
        localparam microword_t NOP_WORD = '{
                alu_dest:  DEST_NONE,
                cin:       1'b0,
                alu_func:  ALU_ONE,
                b_source:  1'b1,
                a_source:  1'b1,
                bop:       BOP_COUNT,
                count:     1'b1,
                next_addr: UADDR_RESET
        };

        always_comb begin
                microword = NOP_WORD;
                case (microaddress)
                UADDR_RESET: begin                         // Flash ones
                        microword.alu_dest  = DEST_F;
                        microword.bop       = BOP_BRANCH;
                        microword.next_addr = UADDR_FLASH;
                end
                UADDR_FLASH: begin                         // Flash zeros, step to wait
                        microword.alu_dest = DEST_F;
                        microword.alu_func = ALU_ZERO;
                end
                UADDR_WAIT: begin                          // Hold ones until go
                        microword.alu_dest  = DEST_F;
                        microword.bop       = BOP_GO_BAR;
                        microword.next_addr = UADDR_WAIT;  // Loop on itself
                end
                UADDR_DISPATCH: begin
                        microword.alu_dest  = DEST_F;
                        microword.bop       = BOP_OPCODE;
                        microword.next_addr = 8'hF1;       // Low nibble 1 used
                end

                // ADD routine
                {OP_ADD, 4'h1}: begin
                        microword.alu_dest = DEST_F;
                        microword.alu_func = ALU_A_PLUS_B;
                end
                {OP_ADD, 4'h2}: begin                      // Done until release
                        microword.bop       = BOP_NOT_GO_BAR;
                        microword.next_addr = {OP_ADD, 4'h2};
                end
                {OP_ADD, 4'h3}: begin
                        microword.bop       = BOP_BRANCH;
                        microword.next_addr = UADDR_WAIT;
                end

                // SUBTRACT routine, a + ~b + 1
                {OP_SUB, 4'h1}: begin
                        microword.alu_dest = DEST_F;
                        microword.cin      = 1'b1;
                        microword.alu_func = ALU_A_MINUS_B;
                end
                {OP_SUB, 4'h2}: begin
                        microword.bop       = BOP_NOT_GO_BAR;
                        microword.next_addr = {OP_SUB, 4'h2};
                end
                {OP_SUB, 4'h3}: begin
                        microword.bop       = BOP_BRANCH;
                        microword.next_addr = UADDR_WAIT;
                end

                // AND routine
                {OP_AND, 4'h1}: begin
                        microword.alu_dest = DEST_F;
                        microword.alu_func = ALU_A_AND_B;
                end
                {OP_AND, 4'h2}: begin
                        microword.bop       = BOP_NOT_GO_BAR;
                        microword.next_addr = {OP_AND, 4'h2};
                end
                {OP_AND, 4'h3}: begin
                        microword.bop       = BOP_BRANCH;
                        microword.next_addr = UADDR_WAIT;
                end

                // OR routine
                {OP_OR, 4'h1}: begin
                        microword.alu_dest = DEST_F;
                        microword.alu_func = ALU_A_OR_B;
                end
                {OP_OR, 4'h2}: begin
                        microword.bop       = BOP_NOT_GO_BAR;
                        microword.next_addr = {OP_OR, 4'h2};
                end
                {OP_OR, 4'h3}: begin
                        microword.bop       = BOP_BRANCH;
                        microword.next_addr = UADDR_WAIT;
                end

                // XOR routine
                {OP_XOR, 4'h1}: begin
                        microword.alu_dest = DEST_F;
                        microword.alu_func = ALU_A_XOR_B;
                end
                {OP_XOR, 4'h2}: begin
                        microword.bop       = BOP_NOT_GO_BAR;
                        microword.next_addr = {OP_XOR, 4'h2};
                end
                {OP_XOR, 4'h3}: begin
                        microword.bop       = BOP_BRANCH;
                        microword.next_addr = UADDR_WAIT;
                end

                default: begin                             // Unmapped, restart
                        microword.alu_dest  = DEST_F;
                        microword.bop       = BOP_BRANCH;
                        microword.next_addr = UADDR_RESET;
                end
                endcase
        end

endmodule

//--- hdl/micro_cpu.sv
/* Top of the microprogrammed arithmetic unit.
   Sequencer, control store and ALU datapath. */

module micro_cpu import micro_pkg::*; #(
        parameter int DATA_WIDTH = 8
) (
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  go_bar,   // Press low to start
        input  opcode_e               opcode,
        input  logic [DATA_WIDTH-1:0] input_a,
        input  logic [DATA_WIDTH-1:0] input_b,
        output logic [DATA_WIDTH-1:0] result,
        output logic                  carry,
        output logic                  idle,     // Ready for go
        output logic                  done      // Result valid until release
);

        uaddr_t     microaddress;  // Sequencer to ROM
        microword_t microword;     // ROM to sequencer and datapath

        micro_sequencer u_micro_sequencer (
                .clk          (clk),
                .rst_n        (rst_n),
                .go_bar       (go_bar),
                .opcode       (opcode),
                .microword    (microword),
                .microaddress (microaddress),
                .idle         (idle),
                .done         (done)
        );

        control_store u_control_store (
                .microaddress (microaddress),
                .microword    (microword)
        );

        alu_datapath #(
                .DATA_WIDTH (DATA_WIDTH)
        ) u_alu_datapath (
                .clk       (clk),
                .rst_n     (rst_n),
                .microword (microword),
                .input_a   (input_a),
                .input_b   (input_b),
                .result    (result),
                .carry     (carry)
        );

endmodule

//--- hdl/micro_pkg.sv
/* Micro program definitions for the microprogrammed 8-bit arithmetic unit.
   Holds the microword layout, the field encodings and the fixed microaddresses. */

package micro_pkg;

        // Microaddress into the 256-word control store
        typedef logic [7:0] uaddr_t;

        // Fixed entry points of the microprogram
        localparam uaddr_t UADDR_RESET    = 8'h00;  // Flash all-ones
        localparam uaddr_t UADDR_FLASH    = 8'h0C;  // Flash all-zeros
        localparam uaddr_t UADDR_WAIT     = 8'h0D;  // Idle loop on go_bar
        localparam uaddr_t UADDR_DISPATCH = 8'h0E;  // Jump on opcode

        // Branch operations, decoded by the sequencer
        typedef enum logic [3:0] {
                BOP_GO_BAR     = 4'b0100,  // Loop while go_bar high
                BOP_NOT_GO_BAR = 4'b1100,  // Loop while go_bar low
                BOP_COUNT      = 4'b0110,  // Plain step
                BOP_BRANCH     = 4'b1110,  // Unconditional jump
                BOP_OPCODE     = 4'b1111   // Opcode becomes high nibble
        } bop_e;

        // ALU functions
        typedef enum logic [4:0] {
                ALU_ONE       = 5'b11100,  // All ones
                ALU_ZERO      = 5'b10011,  // All zeros
                ALU_A_PLUS_B  = 5'b01001,
                ALU_A_MINUS_B = 5'b00110,  // Needs cin set
                ALU_A_AND_B   = 5'b01011,
                ALU_A_OR_B    = 5'b01110,
                ALU_A_XOR_B   = 5'b00100
        } alu_func_e;

        // ALU result destination
        typedef enum logic [2:0] {
                DEST_F    = 3'b011,  // Load F and carry
                DEST_NONE = 3'b111   // Discard
        } alu_dest_e;

        // Macro opcodes, each selects a routine at {opcode, 4'h1}
        typedef enum logic [3:0] {
                OP_ADD = 4'd3,
                OP_SUB = 4'd7,
                OP_AND = 4'd8,
                OP_OR  = 4'd9,
                OP_XOR = 4'd10
        } opcode_e;

        // 24-bit microword, MSB first
        typedef struct packed {
                alu_dest_e alu_dest;   // [23:21]
                logic      cin;        // [20]
                alu_func_e alu_func;   // [19:15]
                logic      b_source;   // [14] 1 is input_b, 0 is F
                logic      a_source;   // [13] 1 is input_a, 0 is F
                bop_e      bop;        // [12:9]
                logic      count;      // [8] Step when not loading
                uaddr_t    next_addr;  // [7:0]
        } microword_t;

endpackage

//--- hdl/micro_sequencer.sv
/* Microsequencer with the micro program counter and a go_bar synchronizer.
   Picks the next microaddress from the branch operation of the current word. */

module micro_sequencer import micro_pkg::*; (
        input  logic       clk,
        input  logic       rst_n,
        input  logic       go_bar,        // Async user request, active low
        input  opcode_e    opcode,        // Stable while go_bar low
        input  microword_t microword,
        output uaddr_t     microaddress,
        output logic       idle,
        output logic       done
);

        logic   go_meta;    // First sync stage
        logic   go_sync;    // Second sync stage
        uaddr_t upc;        // Micro program counter
        uaddr_t upc_step;   // Counted address
        uaddr_t upc_next;

        // Two-flop synchronizer, resets to released
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        go_meta <= 1'b1;
                        go_sync <= 1'b1;
                end else begin
                        go_meta <= go_bar;
                        go_sync <= go_meta;
                end
        end

        assign upc_step = microword.count ? upc + 8'd1 : upc;  // Hold when count clear

        // Next address select
        always_comb begin
                case (microword.bop)
                BOP_BRANCH: upc_next = microword.next_addr;
                BOP_GO_BAR: begin
                        if (go_sync)
                                upc_next = microword.next_addr;  // Still waiting
                        else
                                upc_next = upc_step;             // Go seen
                end
                BOP_NOT_GO_BAR: begin
                        if (!go_sync)
                                upc_next = microword.next_addr;  // Still held
                        else
                                upc_next = upc_step;             // Released
                end
                BOP_OPCODE: upc_next = {opcode, microword.next_addr[3:0]};
                default:    upc_next = upc_step;                 // BOP_COUNT and others
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        upc <= UADDR_RESET;
                else
                        upc <= upc_next;
        end

        assign microaddress = upc;

        // Status from the wait words
        assign idle = (microword.bop == BOP_GO_BAR);
        assign done = (microword.bop == BOP_NOT_GO_BAR);

endmodule

//--- tests/micro_cpu_tb.sv
/* Testbench for the microprogrammed arithmetic unit.
   Table of go_bar operations, expected result and carry worked out here. */

module micro_cpu_tb import micro_pkg::*; ();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int          DATA_WIDTH   = 8;
        localparam int          DRIVE_DELAY  = 5;      // ns after rising edge
        localparam int          RANDOM_ROWS  = 16;
        localparam int          ROW_CYCLES   = 40;     // Watchdog budget per row
        localparam int          EXTRA_CYCLES = 200;    // Reset and slack
        localparam int          SETTLE_CYCLES = 8;     // Covers synchronizer and restart
        localparam logic [31:0] LCG_SEED     = 32'h7503;

        // One table row
        typedef struct packed {
                logic [3:0]            op;    // Raw opcode that may be unmapped
                logic [DATA_WIDTH-1:0] a;
                logic [DATA_WIDTH-1:0] b;
                logic [7:0]            hold;  // Cycles go_bar stays low
        } stim_t;

        logic                  clk;
        logic                  rst_n;
        logic                  go_bar;
        opcode_e               opcode;
        logic [DATA_WIDTH-1:0] input_a;
        logic [DATA_WIDTH-1:0] input_b;
        logic [DATA_WIDTH-1:0] result;
        logic                  carry;
        logic                  idle;
        logic                  done;

        stim_t       stim_q[$];   // Stimulus table
        string       name_q[$];   // Row names by table index
        bit          table_ready;
        logic [31:0] lcg_state;

        tb_clock_gen #(
                .PERIOD_NS    (40),
                .RESET_CYCLES (8)
        ) u_clock_gen (
                .clk   (clk),
                .rst_n (rst_n)
        );

        micro_cpu #(
                .DATA_WIDTH (DATA_WIDTH)
        ) DUT (
                .clk     (clk),
                .rst_n   (rst_n),
                .go_bar  (go_bar),
                .opcode  (opcode),
                .input_a (input_a),
                .input_b (input_b),
                .result  (result),
                .carry   (carry),
                .idle    (idle),
                .done    (done)
        );

        // Print the fail line and stop
        task abort_run;
                $display("ERRORS FOUND");
                $fatal(1, "Simulation stopped at the first failure");
        endtask

        task automatic check_result(input string name, input logic [DATA_WIDTH-1:0] expected,
                                    input logic [DATA_WIDTH-1:0] actual);
                if (actual !== expected) begin
                        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
                        abort_run();
                end
        endtask

        task automatic check_flag(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("ERROR %s: expected %b, actual %b", name, expected, actual);
                        abort_run();
                end
        endtask

        // Numerical Recipes LCG step
        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        // {carry, result} from the arithmetic rules
        function automatic logic [DATA_WIDTH:0] expected_out(input logic [3:0] op,
                                                             input logic [DATA_WIDTH-1:0] a,
                                                             input logic [DATA_WIDTH-1:0] b);
                logic [DATA_WIDTH:0] out;
                case (op)
                OP_ADD:  out = {1'b0, a} + {1'b0, b};  // Carry out of the sum
                OP_SUB:  out = {(a >= b), a - b};       // Carry set when no borrow
                OP_AND:  out = {1'b0, a & b};
                OP_OR:   out = {1'b0, a | b};
                OP_XOR:  out = {1'b0, a ^ b};
                default: out = {1'b0, {DATA_WIDTH{1'b1}}};
                endcase
                return out;
        endfunction

        function automatic bit is_mapped(input logic [3:0] op);
                case (op)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: return 1'b1;
                default:                               return 1'b0;
                endcase
        endfunction

        task automatic add_row(input string name, input logic [3:0] op,
                               input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                               input logic [7:0] hold);
                stim_t row;
                row.op   = op;
                row.a    = a;
                row.b    = b;
                row.hold = hold;
                stim_q.push_back(row);
                name_q.push_back(name);
        endtask

        task automatic fill_table;
                logic [31:0]           r;
                logic [3:0]            op;
                logic [DATA_WIDTH-1:0] a;
                logic [DATA_WIDTH-1:0] b;
                logic [7:0]            hold;
                add_row("add_ff_01", OP_ADD, 8'hFF, 8'h01, 8'd1);   // Wraps to zero
                add_row("add_00_00", OP_ADD, 8'h00, 8'h00, 8'd2);
                add_row("add_80_80", OP_ADD, 8'h80, 8'h80, 8'd3);
                add_row("sub_00_01", OP_SUB, 8'h00, 8'h01, 8'd1);   // Borrow
                add_row("sub_05_05", OP_SUB, 8'h05, 8'h05, 8'd2);
                add_row("sub_ff_00", OP_SUB, 8'hFF, 8'h00, 8'd1);
                add_row("and_ff_0f", OP_AND, 8'hFF, 8'h0F, 8'd1);
                add_row("or_f0_0f",  OP_OR,  8'hF0, 8'h0F, 8'd4);
                add_row("xor_aa_55", OP_XOR, 8'hAA, 8'h55, 8'd1);
                add_row("xor_ff_ff", OP_XOR, 8'hFF, 8'hFF, 8'd20);  // Longest hold
                add_row("unmapped_op0", 4'h0, 8'h12, 8'h34, 8'd8);  // Falls to default word
                add_row("unmapped_op5", 4'h5, 8'h56, 8'h78, 8'd8);
                add_row("unmapped_opf", 4'hF, 8'h9A, 8'hBC, 8'd3);
                for (int i = 0; i < RANDOM_ROWS; i++) begin
                        r = lcg_next();
                        case ((r >> 16) % 32'd5)
                        0:       op = OP_ADD;
                        1:       op = OP_SUB;
                        2:       op = OP_AND;
                        3:       op = OP_OR;
                        default: op = OP_XOR;
                        endcase
                        r    = lcg_next();
                        a    = r[23:16];
                        r    = lcg_next();
                        b    = r[23:16];
                        r    = lcg_next();
                        hold = 8'((r >> 16) % 32'd20 + 32'd1);  // 1 to 20
                        add_row($sformatf("rand_%0d", i), op, a, b, hold);
                end
        endtask

        // Drive go_bar just after a rising edge
        task automatic drive_go(input logic level);
                @(posedge clk);
                #(DRIVE_DELAY);
                go_bar = level;
        endtask

        task automatic start_operation(input stim_t stim);
                @(posedge clk);
                #(DRIVE_DELAY);
                opcode  = opcode_e'(stim.op);
                input_a = stim.a;
                input_b = stim.b;
                go_bar  = 1'b0;  // Press
        endtask

        // Wait for idle then expect all-ones from the second idle cycle
        task automatic wait_idle_settled(input string name);
                @(negedge clk);
                while (idle !== 1'b1) begin
                        check_flag({name, " done before idle"}, 1'b0, done);
                        @(negedge clk);
                end
                @(negedge clk);
                check_flag({name, " idle"}, 1'b1, idle);
                check_flag({name, " done in idle"}, 1'b0, done);
                check_result({name, " idle result"}, {DATA_WIDTH{1'b1}}, result);
                check_flag({name, " idle carry"}, 1'b0, carry);
        endtask

        task automatic run_operation(input string name, input stim_t stim);
                logic [DATA_WIDTH:0]   exp;
                logic [DATA_WIDTH-1:0] exp_res;
                logic                  exp_carry;
                exp       = expected_out(stim.op, stim.a, stim.b);
                exp_res   = exp[DATA_WIDTH-1:0];
                exp_carry = exp[DATA_WIDTH];
                start_operation(stim);
                @(negedge clk);
                while (done !== 1'b1)
                        @(negedge clk);  // Latency set by synchronizer
                check_result(name, exp_res, result);
                check_flag({name, " carry"}, exp_carry, carry);
                for (int i = 1; i < stim.hold; i++) begin
                        @(negedge clk);
                        check_flag({name, " done held"}, 1'b1, done);
                        check_result({name, " held"}, exp_res, result);
                        check_flag({name, " carry held"}, exp_carry, carry);
                end
                drive_go(1'b1);
                @(negedge clk);
                while (done === 1'b1) begin  // Release still in synchronizer
                        check_result({name, " release"}, exp_res, result);
                        check_flag({name, " carry release"}, exp_carry, carry);
                        @(negedge clk);
                end
                check_flag({name, " idle on return"}, 1'b0, idle);  // Branch back word
                wait_idle_settled(name);
        endtask

        // Unmapped opcode restarts the reset sequence without done
        task automatic run_unmapped(input string name, input stim_t stim);
                start_operation(stim);
                repeat (stim.hold) begin
                        @(negedge clk);
                        check_flag({name, " done"}, 1'b0, done);
                end
                drive_go(1'b1);
                repeat (SETTLE_CYCLES) begin
                        @(negedge clk);
                        check_flag({name, " done after release"}, 1'b0, done);
                end
                wait_idle_settled(name);
        endtask

        initial begin : watchdog
                int limit;
                wait (table_ready);
                limit = stim_q.size() * ROW_CYCLES + EXTRA_CYCLES;
                repeat (limit) @(posedge clk);
                $display("Timeout after %0d cycles, the DUT never reached idle or done", limit);
                abort_run();
        end

        initial begin : stimulus
                go_bar      = 1'b1;
                opcode      = OP_ADD;
                input_a     = '0;
                input_b     = '0;
                lcg_state   = LCG_SEED;
                fill_table();
                table_ready = 1'b1;
                @(negedge clk);  // Still in reset
                check_result("reset result", '0, result);
                check_flag("reset carry", 1'b0, carry);
                check_flag("reset idle", 1'b0, idle);
                check_flag("reset done", 1'b0, done);
                wait (rst_n === 1'b1);
                wait_idle_settled("after reset");
                foreach (stim_q[i]) begin
                        if (is_mapped(stim_q[i].op))
                                run_operation(name_q[i], stim_q[i]);
                        else
                                run_unmapped(name_q[i], stim_q[i]);
                end
                $display("NO ERRORS");
                $finish;
        end

endmodule

//--- tests/tb_clock_gen.sv
/* Clock and reset source for the arithmetic unit testbench.
   Free running clock, reset held low for a fixed number of cycles. */

module tb_clock_gen #(
        parameter int PERIOD_NS    = 40,
        parameter int RESET_CYCLES = 8,
        parameter int RELEASE_NS   = 5   // Release just after an edge
) (
        output logic clk,
        output logic rst_n
);
        timeunit 1ns;
        timeprecision 1ps;

        initial begin
                clk = 1'b0;
                forever #(PERIOD_NS / 2) clk = ~clk;
        end

        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                #(RELEASE_NS) rst_n = 1'b1;
        end

endmodule
